// File: serial_pkg.sv
// serial line framing constants and receiver/transmitter state encodings
package serial_pkg;

	// line levels
	localparam logic serial_start = 1'b0;
	localparam logic serial_stop = 1'b1;

	// data bits per byte
	localparam int word_bits = 8;

	// receiver states
	typedef enum logic [2:0] {
		Ready = 3'd0,
		ReceiveStartCont = 3'd1,
		WaitCycle = 3'd2,
		ReceiveData = 3'd3,
		ReceiveStop = 3'd4,
		Error = 3'd5
	} rx_state_t;

	// transmitter states
	typedef enum logic [1:0] {
		Idle = 2'd0,
		SendStart = 2'd1,
		SendData = 2'd2,
		SendStop = 2'd3
	} tx_state_t;

endpackage

// File: cmd_pkg.sv
// command engine opcodes, decoder states and reply codes
package cmd_pkg;

	// opcode in bits 7:6 of the command byte
	typedef enum logic [1:0] {
		op_write = 2'd0,
		op_add = 2'd1,
		op_xor = 2'd2,
		op_read = 2'd3
	} opcode_t;

	// command byte / operand byte pairing
	typedef enum logic {
		WaitCommand = 1'b0,
		WaitOperand = 1'b1
	} dec_state_t;

	// reply for a command with reserved bits set
	localparam logic [7:0] reply_bad_command = 8'hEE;

	// size of the register file
	localparam int reg_count = 4;

endpackage

// File: serial_async_rx.sv
// asynchronous serial receiver, oversamples the line and delivers bytes
`timescale 1ns/1ps

module serial_async_rx #(
	parameter int clk_multiple = 8,
	parameter int stop_bits = 1,
	parameter bit lowbit_first = 1'b1
) (
	input logic serial_clk,
	input logic in_rst,
	input logic enable,
	input logic serial_in,
	output logic idle,
	output logic [serial_pkg::word_bits-1:0] data,
	output logic valid,
	output logic frame_error
);

	localparam int cnt_w = $clog2(clk_multiple + 1);
	localparam int bit_w = $clog2(serial_pkg::word_bits);

	serial_pkg::rx_state_t state;
	serial_pkg::rx_state_t after_wait;
	logic [cnt_w-1:0] multi_ctr;
	logic [bit_w-1:0] bit_ctr;
	logic [bit_w-1:0] bit_pos;
	logic last_stop;
	logic line_stop;

	// position of the current data bit in the word
	assign bit_pos = lowbit_first ? bit_ctr : bit_w'(serial_pkg::word_bits - 1) - bit_ctr;
	assign last_stop = bit_ctr == bit_w'(stop_bits - 1);
	assign line_stop = serial_in == serial_pkg::serial_stop;

	assign idle = state == serial_pkg::Ready;
	assign valid = state == serial_pkg::ReceiveStop && line_stop && last_stop;
	assign frame_error = state == serial_pkg::ReceiveStop && !line_stop;

	always_ff @(posedge serial_clk or posedge in_rst) begin
		if (in_rst) begin
			state <= serial_pkg::Ready;
			after_wait <= serial_pkg::Ready;
			multi_ctr <= '0;
			bit_ctr <= '0;
		end else begin
			case (state)
				serial_pkg::Ready: begin
					bit_ctr <= '0;
					// falling edge counts as the first cycle of the start bit
					if (enable && serial_in == serial_pkg::serial_start) begin
						state <= serial_pkg::ReceiveStartCont;
						multi_ctr <= cnt_w'(1);
					end
				end

				serial_pkg::ReceiveStartCont: begin
					if (!enable || serial_in != serial_pkg::serial_start) begin
						// glitch on the line, wait for the next edge
						state <= serial_pkg::Ready;
						multi_ctr <= '0;
					end else if (multi_ctr == cnt_w'(clk_multiple / 2)) begin
						state <= serial_pkg::WaitCycle;
						after_wait <= serial_pkg::ReceiveData;
						multi_ctr <= '0;
					end else begin
						multi_ctr <= multi_ctr + 1'b1;
					end
				end

				serial_pkg::WaitCycle: begin
					// the sampling state takes one cycle of the bit period
					if (multi_ctr == cnt_w'(clk_multiple - 2)) begin
						state <= after_wait;
						multi_ctr <= '0;
					end else begin
						multi_ctr <= multi_ctr + 1'b1;
					end
				end

				serial_pkg::ReceiveData: begin
					state <= serial_pkg::WaitCycle;
					if (bit_ctr == bit_w'(serial_pkg::word_bits - 1)) begin
						bit_ctr <= '0;
						after_wait <= serial_pkg::ReceiveStop;
					end else begin
						bit_ctr <= bit_ctr + 1'b1;
						after_wait <= serial_pkg::ReceiveData;
					end
				end

				serial_pkg::ReceiveStop: begin
					if (!line_stop) begin
						state <= serial_pkg::Error;
						multi_ctr <= '0;
					end else if (last_stop) begin
						state <= serial_pkg::Ready;
						bit_ctr <= '0;
					end else begin
						state <= serial_pkg::WaitCycle;
						after_wait <= serial_pkg::ReceiveStop;
						bit_ctr <= bit_ctr + 1'b1;
					end
				end

				serial_pkg::Error: begin
					// need a full bit time of idle line to recover
					if (!line_stop) begin
						multi_ctr <= '0;
					end else if (multi_ctr == cnt_w'(clk_multiple - 1)) begin
						state <= serial_pkg::Ready;
						multi_ctr <= '0;
					end else begin
						multi_ctr <= multi_ctr + 1'b1;
					end
				end

				default: begin
					state <= serial_pkg::Ready;
				end
			endcase
		end
	end

	// data bits land at their place as they are sampled
	always_ff @(posedge serial_clk) begin
		if (state == serial_pkg::ReceiveData) begin
			data[bit_pos] <= serial_in;
		end
	end

endmodule

// File: serial_async_tx.sv
// asynchronous serial transmitter, sends one framed byte per request
`timescale 1ns/1ps

module serial_async_tx #(
	parameter int clk_multiple = 8,
	parameter int stop_bits = 1,
	parameter bit lowbit_first = 1'b1
) (
	input logic serial_clk,
	input logic in_rst,
	input logic [serial_pkg::word_bits-1:0] data,
	input logic start,
	output logic serial_out,
	output logic busy
);

	localparam int cnt_w = $clog2(clk_multiple + 1);
	localparam int bit_w = $clog2(serial_pkg::word_bits);

	serial_pkg::tx_state_t state;
	logic [cnt_w-1:0] div_ctr;
	logic [bit_w-1:0] bit_ctr;
	logic [serial_pkg::word_bits-1:0] shift_reg;
	logic bit_end;
	logic first_bit;
	logic next_bit;

	assign bit_end = div_ctr == cnt_w'(clk_multiple - 1);
	assign first_bit = lowbit_first ? shift_reg[0] : shift_reg[serial_pkg::word_bits-1];
	assign next_bit = lowbit_first ? shift_reg[1] : shift_reg[serial_pkg::word_bits-2];

	// a start request already counts as busy
	assign busy = state != serial_pkg::Idle || start;

	always_ff @(posedge serial_clk or posedge in_rst) begin
		if (in_rst) begin
			state <= serial_pkg::Idle;
			div_ctr <= '0;
			bit_ctr <= '0;
			serial_out <= serial_pkg::serial_stop;
		end else begin
			if (state == serial_pkg::Idle || bit_end) begin
				div_ctr <= '0;
			end else begin
				div_ctr <= div_ctr + 1'b1;
			end

			case (state)
				serial_pkg::Idle: begin
					bit_ctr <= '0;
					if (start) begin
						state <= serial_pkg::SendStart;
						serial_out <= serial_pkg::serial_start;
					end
				end
				serial_pkg::SendStart: begin
					if (bit_end) begin
						state <= serial_pkg::SendData;
						serial_out <= first_bit;
					end
				end
				serial_pkg::SendData: begin
					if (bit_end && bit_ctr == bit_w'(serial_pkg::word_bits - 1)) begin
						state <= serial_pkg::SendStop;
						serial_out <= serial_pkg::serial_stop;
						bit_ctr <= '0;
					end else if (bit_end) begin
						bit_ctr <= bit_ctr + 1'b1;
						serial_out <= next_bit;
					end
				end
				serial_pkg::SendStop: begin
					if (bit_end && bit_ctr == bit_w'(stop_bits - 1)) begin
						state <= serial_pkg::Idle;
					end else if (bit_end) begin
						bit_ctr <= bit_ctr + 1'b1;
					end
				end
				default: begin
					state <= serial_pkg::Idle;
				end
			endcase
		end
	end

	// outgoing bit is always at the end selected by the bit order
	always_ff @(posedge serial_clk) begin
		if (state == serial_pkg::Idle && start) begin
			shift_reg <= data;
		end else if (state == serial_pkg::SendData && bit_end) begin
			shift_reg <= lowbit_first ? shift_reg >> 1 : shift_reg << 1;
		end
	end

endmodule

// File: cmd_decode.sv
// command decoder, pairs received bytes into commands and checks the command byte
`timescale 1ns/1ps

module cmd_decode (
	input logic serial_clk,
	input logic in_rst,
	input logic [7:0] rx_data,
	input logic rx_valid,
	input logic frame_error,
	output cmd_pkg::opcode_t opcode,
	output logic [$clog2(cmd_pkg::reg_count)-1:0] reg_index,
	output logic [7:0] operand,
	output logic bad,
	output logic valid
);

	cmd_pkg::dec_state_t state;
	logic [7:0] cmd_byte;
	logic operand_in;

	assign operand_in = rx_valid && state == cmd_pkg::WaitOperand;

	always_ff @(posedge serial_clk or posedge in_rst) begin
		if (in_rst) begin
			state <= cmd_pkg::WaitCommand;
			valid <= 1'b0;
		end else begin
			valid <= 1'b0;
			if (frame_error) begin
				// drop any half command
				state <= cmd_pkg::WaitCommand;
			end else if (rx_valid && state == cmd_pkg::WaitCommand) begin
				state <= cmd_pkg::WaitOperand;
			end else if (operand_in) begin
				state <= cmd_pkg::WaitCommand;
				valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge serial_clk) begin
		if (rx_valid && state == cmd_pkg::WaitCommand) begin
			cmd_byte <= rx_data;
		end
		if (operand_in) begin
			opcode <= cmd_pkg::opcode_t'(cmd_byte[7:6]);
			reg_index <= cmd_byte[1:0];
			operand <= rx_data;
			// reserved bits must be zero
			bad <= cmd_byte[5:2] != 4'b0000;
		end
	end

endmodule

// File: cmd_execute.sv
// execute stage, applies the opcode to the selected register of the register file
`timescale 1ns/1ps

module cmd_execute (
	input logic serial_clk,
	input logic in_rst,
	input cmd_pkg::opcode_t opcode,
	input logic [$clog2(cmd_pkg::reg_count)-1:0] reg_index,
	input logic [7:0] operand,
	input logic bad,
	input logic valid,
	output logic [7:0] value,
	output logic result_bad,
	output logic result_valid
);

	logic [7:0] regs [cmd_pkg::reg_count];
	logic [7:0] current;
	logic [7:0] updated;

	assign current = regs[reg_index];

	always_comb begin
		updated = current;
		case (opcode)
			cmd_pkg::op_write: updated = operand;
			// wraps modulo 256
			cmd_pkg::op_add: updated = current + operand;
			cmd_pkg::op_xor: updated = current ^ operand;
			cmd_pkg::op_read: updated = current;
			default: updated = current;
		endcase
	end

	always_ff @(posedge serial_clk or posedge in_rst) begin
		if (in_rst) begin
			for (int i = 0; i < cmd_pkg::reg_count; i++) begin
				regs[i] <= '0;
			end
			result_valid <= 1'b0;
		end else begin
			result_valid <= valid;
			if (valid && !bad) begin
				regs[reg_index] <= updated;
			end
		end
	end

	// value after the operation goes to the reply
	always_ff @(posedge serial_clk) begin
		if (valid) begin
			value <= updated;
			result_bad <= bad;
		end
	end

endmodule

// File: cmd_result.sv
// result stage, picks the reply byte and holds it until the transmitter is free
`timescale 1ns/1ps

module cmd_result (
	input logic serial_clk,
	input logic in_rst,
	input logic [7:0] value,
	input logic bad,
	input logic valid,
	input logic tx_busy,
	output logic [7:0] tx_data,
	output logic tx_start
);

	logic [7:0] reply;
	logic [7:0] hold_byte;
	logic hold_valid;
	logic send_hold;
	logic send_new;

	assign reply = bad ? cmd_pkg::reply_bad_command : value;
	assign send_hold = hold_valid && !tx_busy;
	assign send_new = valid && !hold_valid && !tx_busy;

	always_ff @(posedge serial_clk or posedge in_rst) begin
		if (in_rst) begin
			tx_start <= 1'b0;
			hold_valid <= 1'b0;
		end else begin
			tx_start <= send_hold || send_new;
			if (send_hold) begin
				hold_valid <= valid;
			end else if (valid && !send_new) begin
				hold_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge serial_clk) begin
		if (send_hold) begin
			tx_data <= hold_byte;
		end else if (send_new) begin
			tx_data <= reply;
		end
		// parked here while the transmitter is busy
		if (valid && !send_new) begin
			hold_byte <= reply;
		end
	end

endmodule

// File: serial_cmd_top.sv
// serial command engine, receiver through decode, execute and result to transmitter
`timescale 1ns/1ps

module serial_cmd_top #(
	parameter int clk_multiple = 8,
	parameter int stop_bits = 1,
	parameter bit lowbit_first = 1'b1
) (
	input logic serial_clk,
	input logic in_rst,
	input logic rx_enable,
	input logic serial_in,
	output logic serial_out,
	output logic rx_idle
);

	logic [7:0] rx_byte;
	logic rx_valid;
	logic frame_error;

	cmd_pkg::opcode_t cmd_opcode;
	logic [1:0] cmd_reg;
	logic [7:0] cmd_operand;
	logic cmd_bad;
	logic cmd_valid;

	logic [7:0] exec_value;
	logic exec_bad;
	logic exec_valid;

	logic [7:0] tx_byte;
	logic tx_start;
	logic tx_busy;

	serial_async_rx #(
		.clk_multiple(clk_multiple),
		.stop_bits(stop_bits),
		.lowbit_first(lowbit_first)
	) rx_inst (
		.serial_clk(serial_clk),
		.in_rst(in_rst),
		.enable(rx_enable),
		.serial_in(serial_in),
		.idle(rx_idle),
		.data(rx_byte),
		.valid(rx_valid),
		.frame_error(frame_error)
	);

	cmd_decode decode_inst (
		.serial_clk(serial_clk),
		.in_rst(in_rst),
		.rx_data(rx_byte),
		.rx_valid(rx_valid),
		.frame_error(frame_error),
		.opcode(cmd_opcode),
		.reg_index(cmd_reg),
		.operand(cmd_operand),
		.bad(cmd_bad),
		.valid(cmd_valid)
	);

	cmd_execute execute_inst (
		.serial_clk(serial_clk),
		.in_rst(in_rst),
		.opcode(cmd_opcode),
		.reg_index(cmd_reg),
		.operand(cmd_operand),
		.bad(cmd_bad),
		.valid(cmd_valid),
		.value(exec_value),
		.result_bad(exec_bad),
		.result_valid(exec_valid)
	);

	cmd_result result_inst (
		.serial_clk(serial_clk),
		.in_rst(in_rst),
		.value(exec_value),
		.bad(exec_bad),
		.valid(exec_valid),
		.tx_busy(tx_busy),
		.tx_data(tx_byte),
		.tx_start(tx_start)
	);

	serial_async_tx #(
		.clk_multiple(clk_multiple),
		.stop_bits(stop_bits),
		.lowbit_first(lowbit_first)
	) tx_inst (
		.serial_clk(serial_clk),
		.in_rst(in_rst),
		.data(tx_byte),
		.start(tx_start),
		.serial_out(serial_out),
		.busy(tx_busy)
	);

endmodule

// File: tb_serial_cmd.sv
// testbench for the serial command engine with random commands checked against a register model
`timescale 1ns/1ps

module tb_serial_cmd;

	localparam int clk_multiple = 8;
	localparam int stop_bits = 1;
	localparam bit lowbit_first = 1'b1;
	localparam int n_random = 40;
	localparam int n_bad = 3;
	localparam int n_burst = 30;
	localparam int total_commands = n_random + 2 * n_bad + n_burst + 4;
	localparam int timeout_cycles = total_commands * 40 * clk_multiple + 200 * clk_multiple;

	logic serial_clk;
	logic in_rst;
	logic rx_enable;
	logic serial_in;
	logic serial_out;
	logic rx_idle;

	logic [7:0] model_regs [4];
	logic [7:0] expected_q [$];
	int cycle_count;
	int unsigned seed_sink;

	serial_cmd_top #(
		.clk_multiple(clk_multiple),
		.stop_bits(stop_bits),
		.lowbit_first(lowbit_first)
	) uut (
		.serial_clk(serial_clk),
		.in_rst(in_rst),
		.rx_enable(rx_enable),
		.serial_in(serial_in),
		.serial_out(serial_out),
		.rx_idle(rx_idle)
	);

	initial begin
		serial_clk = 1'b0;
		forever #10 serial_clk = ~serial_clk;
	end

	task automatic stop_with_error(input string what);
		$display("%s", what);
		$display("Simulation failed");
		$fatal(1, "run stopped at the first error");
	endtask

	// watchdog
	always @(posedge serial_clk) begin
		cycle_count <= cycle_count + 1;
		assert (cycle_count <= timeout_cycles)
			else stop_with_error("timeout: the run took longer than its cycle limit");
	end

	task automatic idle_bits(input int n);
		serial_in = 1'b1;
		repeat (n * clk_multiple) @(negedge serial_clk);
	endtask

	// one frame on serial_in from one falling edge to another
	task automatic send_byte(input logic [7:0] value, input logic stop_level);
		serial_in = 1'b0;
		repeat (clk_multiple) @(negedge serial_clk);
		for (int i = 0; i < 8; i++) begin
			serial_in = lowbit_first ? value[i] : value[7-i];
			repeat (clk_multiple) @(negedge serial_clk);
		end
		for (int s = 0; s < stop_bits; s++) begin
			serial_in = stop_level;
			repeat (clk_multiple) @(negedge serial_clk);
		end
		serial_in = 1'b1;
	endtask

	// model update and expected reply, then the two bytes on the line
	task automatic send_command(input cmd_pkg::opcode_t op, input logic [1:0] idx,
			input logic [7:0] operand, input logic [3:0] reserved, input int gap,
			input bit expect_reply);
		logic [7:0] cmd_byte;
		cmd_byte = {op, reserved, idx};
		if (expect_reply) begin
			if (reserved != 4'd0) begin
				expected_q.push_back(8'hEE);
			end else begin
				case (op)
					cmd_pkg::op_write: model_regs[idx] = operand;
					cmd_pkg::op_add: model_regs[idx] = model_regs[idx] + operand;
					cmd_pkg::op_xor: model_regs[idx] = model_regs[idx] ^ operand;
					default: model_regs[idx] = model_regs[idx];
				endcase
				expected_q.push_back(model_regs[idx]);
			end
		end
		send_byte(cmd_byte, 1'b1);
		idle_bits(gap);
		send_byte(operand, 1'b1);
	endtask

	task automatic wait_replies();
		while (expected_q.size() != 0) begin
			@(negedge serial_clk);
		end
		idle_bits(4);
	endtask

	// decodes serial_out at bit middles
	initial begin : reply_monitor
		logic [7:0] got;
		logic [7:0] exp;
		wait (in_rst == 1'b0);
		forever begin
			@(negedge serial_clk);
			if (serial_out == 1'b0) begin
				repeat (clk_multiple / 2) @(negedge serial_clk);
				assert (serial_out == 1'b0)
					else stop_with_error("start bit on serial_out ended before its middle");
				for (int i = 0; i < 8; i++) begin
					repeat (clk_multiple) @(negedge serial_clk);
					got[lowbit_first ? i : 7 - i] = serial_out;
				end
				for (int s = 0; s < stop_bits; s++) begin
					repeat (clk_multiple) @(negedge serial_clk);
					assert (serial_out == 1'b1)
						else stop_with_error($sformatf(
							"[FAIL] time=%0t signal=serial_out stop bit expected=1 actual=%0b",
							$time, serial_out));
				end
				assert (expected_q.size() > 0)
					else stop_with_error("a reply byte arrived while no command was waiting for one");
				exp = expected_q.pop_front();
				assert (got == exp)
					else stop_with_error($sformatf(
						"[FAIL] time=%0t signal=serial_out expected=%02h actual=%02h",
						$time, exp, got));
			end
		end
	end

	initial begin : stimulus
		cmd_pkg::opcode_t op;
		logic [1:0] idx;
		in_rst = 1'b1;
		rx_enable = 1'b1;
		serial_in = 1'b1;
		cycle_count = 0;
		for (int r = 0; r < 4; r++) begin
			model_regs[r] = 8'h00;
		end
		seed_sink = $urandom(32'h7c787c79);
		repeat (2) @(posedge serial_clk);
		@(negedge serial_clk);
		in_rst = 1'b0;

		// quiet line after reset
		repeat (4 * clk_multiple) begin
			@(negedge serial_clk);
			assert (serial_out == 1'b1)
				else stop_with_error($sformatf("[FAIL] time=%0t signal=serial_out expected=1 actual=%0b",
					$time, serial_out));
			assert (rx_idle == 1'b1)
				else stop_with_error($sformatf("[FAIL] time=%0t signal=rx_idle expected=1 actual=%0b",
					$time, rx_idle));
		end

		// random traffic
		for (int k = 0; k < n_random; k++) begin
			op = cmd_pkg::opcode_t'($urandom_range(3, 0));
			send_command(op, 2'($urandom_range(3, 0)), 8'($urandom), 4'd0, 1, 1'b1);
			idle_bits(1);
		end

		// reserved bits set, then a read of the same register
		for (int k = 0; k < n_bad; k++) begin
			op = cmd_pkg::opcode_t'($urandom_range(3, 0));
			idx = 2'($urandom_range(3, 0));
			send_command(op, idx, 8'($urandom), 4'($urandom_range(15, 1)), 1, 1'b1);
			idle_bits(1);
			send_command(cmd_pkg::op_read, idx, 8'($urandom), 4'd0, 1, 1'b1);
			idle_bits(1);
		end
		wait_replies();

		// lone command byte, then a framing error, then a full command
		send_byte({cmd_pkg::op_write, 4'd0, 2'($urandom_range(3, 0))}, 1'b1);
		idle_bits(1);
		send_byte(8'($urandom), 1'b0);
		idle_bits(2);
		send_command(cmd_pkg::op_add, 2'($urandom_range(3, 0)), 8'($urandom), 4'd0, 1, 1'b1);
		wait_replies();

		// bursts with short random gaps
		for (int k = 0; k < n_burst; k++) begin
			op = cmd_pkg::opcode_t'($urandom_range(3, 0));
			send_command(op, 2'($urandom_range(3, 0)), 8'($urandom), 4'd0,
				$urandom_range(3, 0), 1'b1);
			idle_bits($urandom_range(3, 0));
		end
		wait_replies();

		// command sent while the receiver is disabled
		idx = 2'($urandom_range(3, 0));
		rx_enable = 1'b0;
		send_command(cmd_pkg::op_write, idx, 8'($urandom), 4'd0, 1, 1'b0);
		idle_bits(30);
		rx_enable = 1'b1;
		idle_bits(1);
		send_command(cmd_pkg::op_read, idx, 8'($urandom), 4'd0, 1, 1'b1);
		wait_replies();
		idle_bits(20);

		$display("Simulation passed");
		$finish;
	end

endmodule

// File: project.f
serial_pkg.sv
cmd_pkg.sv
serial_async_rx.sv
serial_async_tx.sv
cmd_decode.sv
cmd_execute.sv
cmd_result.sv
serial_cmd_top.sv
tb_serial_cmd.sv

// File: run_sim.sh
#!/bin/bash
# builds the testbench with Verilator and runs it, passing only on the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_serial_cmd -f project.f -o tb_sim \
	&& ./obj_dir/tb_sim | tee /dev/stderr | grep -q "Simulation passed" \
	&& echo "run ok" \
	|| { echo "run not ok"; exit 1; }
